/* Bender.yml */
package:
  name: pcs_block_sync

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pcs_block_pkg.sv
      - rtl/block_lock_pkg.sv
      - rtl/aligned_block_if.sv
      - rtl/block_aligner.sv
      - rtl/block_sync_fsm.sv
      - rtl/pcs_block_sync.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/clock_gen.sv
      - bench/tb_pcs_block_sync.sv

/* bench/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen
#(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
)
(
	output logic o_clock,
	output logic o_rst_n
);

	initial
	begin
		o_clock = 1'b0;
		forever
			#(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// low over the first rising edges
	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_rst_n <= 1'b1;
	end

endmodule

/* bench/tb_pcs_block_sync.sv */
`timescale 1ns/1ns
`include "pcs_params.svh"

module tb_pcs_block_sync;

	localparam int BL          = `PCS_BLOCK_LEN;
	localparam int PL          = `PCS_PAYLOAD_LEN;
	localparam int CLK_NS      = 8;
	localparam int N_ROWS      = 6;
	localparam int PHASE_LIMIT = 2000; // cycles allowed for one acquisition
	localparam int ROW_WORDS   = 2 * PHASE_LIMIT + 200;
	localparam int WATCHDOG_NS = (N_ROWS * ROW_WORDS + 16) * CLK_NS;

	// skew in bits, headers corrupted while locked, loss of lock expected
	int   skew_tab    [N_ROWS] = '{0,  1,  33, 65, 17, 64};
	int   corrupt_tab [N_ROWS] = '{64, 65, 64, 65, 0,  65};
	logic loss_tab    [N_ROWS] = '{0,  1,  0,  1,  0,  1};

	logic                              i_clock;
	logic                              i_rst_n;
	logic                              i_signal_ok;
	logic                              i_word_valid;
	logic [BL-1:0]                     i_word;
	logic                              o_block_valid;
	logic                              o_block_lock;
	logic                              o_block_is_ctrl;
	logic [PL-1:0]                     o_block_payload;
	logic [7:0]                        o_block_type;
	logic [$clog2(BL)-1:0]             o_offset;

	logic [31:0]   lfsr_state;
	logic          rx_bits[$];    // line bits not yet cut into words
	logic [1:0]    tx_header[$];  // bit 0 goes out first
	logic [PL-1:0] tx_payload[$];
	int            drv_w;         // index of the word driven last
	int            corrupt_left;
	int            skew;
	int            mismatch_count;
	int            other_count;

	clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) u_clock_gen
	(
		.o_clock (i_clock),
		.o_rst_n (i_rst_n)
	);

	pcs_block_sync u_dut
	(
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_signal_ok     (i_signal_ok),
		.i_word_valid    (i_word_valid),
		.i_word          (i_word),
		.o_block_valid   (o_block_valid),
		.o_block_lock    (o_block_lock),
		.o_block_is_ctrl (o_block_is_ctrl),
		.o_block_payload (o_block_payload),
		.o_block_type    (o_block_type),
		.o_offset        (o_offset)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr_state[31];
		lfsr_state = lfsr_next(lfsr_state);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_problem(input string msg);
		other_count++;
		$display("error: %s at %0t", msg, $time);
	endtask

	task automatic append_block();
		logic          kind;
		logic [1:0]    hdr;
		logic [PL-1:0] pay;
		take_bit(kind);
		for (int i = 0; i < PL; i++)
			take_bit(pay[i]);
		hdr = kind ? 2'b01 : 2'b10; // control "10" on the line, data "01"
		if (corrupt_left > 0)
		begin
			hdr[1] = ~hdr[1]; // gives 00 or 11
			corrupt_left--;
		end
		tx_header.push_back(hdr);
		tx_payload.push_back(pay);
		rx_bits.push_back(hdr[0]);
		rx_bits.push_back(hdr[1]);
		for (int i = 0; i < PL; i++)
			rx_bits.push_back(pay[i]);
	endtask

	// k junk bits ahead of the first block
	task automatic start_stream(input int k);
		logic junk;
		rx_bits.delete();
		tx_header.delete();
		tx_payload.delete();
		drv_w        = -1;
		corrupt_left = 0;
		for (int i = 0; i < k; i++)
		begin
			take_bit(junk);
			rx_bits.push_back(junk);
		end
	endtask

	task automatic drive_word();
		logic [BL-1:0] word;
		while (rx_bits.size() < BL)
			append_block();
		for (int i = 0; i < BL; i++)
			word[i] = rx_bits.pop_front();
		@(posedge i_clock);
		i_word       <= word;
		i_word_valid <= 1'b1;
		drv_w++;
	endtask

	task automatic step_cycle();
		int   idx;
		logic exp_ctrl;
		drive_word();
		@(negedge i_clock);
		if (o_block_lock)
		begin
			idx      = drv_w - 2; // block cut from the two words before
			exp_ctrl = (tx_header[idx] == 2'b01);
			check_value("o_offset", o_offset, skew);
			check_value("o_block_valid", o_block_valid, 1);
			check_value("o_block_payload", o_block_payload, tx_payload[idx]);
			check_value("o_block_is_ctrl", o_block_is_ctrl, exp_ctrl);
			check_value("o_block_type", o_block_type, exp_ctrl ? tx_payload[idx][7:0] : 8'h00);
		end
	endtask

	// one cycle of signal loss, then a fresh stream
	task automatic restart_link(input int k);
		@(posedge i_clock);
		i_signal_ok <= 1'b0;
		start_stream(k);
		drive_word();
		i_signal_ok <= 1'b1;
		@(negedge i_clock);
		check_value("o_block_valid", o_block_valid, 0);
		check_value("o_block_lock", o_block_lock, 0);
		check_value("o_offset", o_offset, 0);
	endtask

	task automatic wait_lock(input string phase);
		int n;
		n = 0;
		while (!o_block_lock && n < PHASE_LIMIT)
		begin
			step_cycle();
			n++;
		end
		if (!o_block_lock)
			report_problem($sformatf("no lock during %s at skew %0d", phase, skew));
		else
			check_value("o_offset", o_offset, skew);
	endtask

	task automatic run_row(input int k, input int n_bad, input logic loss);
		skew = k;
		restart_link(k);
		wait_lock("acquisition");
		repeat (16) step_cycle();
		corrupt_left = n_bad; // applies to the next blocks built
		repeat (n_bad + 16) step_cycle();
		check_value("o_block_lock", o_block_lock, !loss);
		if (loss)
		begin
			if (o_offset == skew)
				report_problem($sformatf("offset stayed at %0d after loss of lock", skew));
			wait_lock("relock");
			repeat (16) step_cycle();
		end
		else
			check_value("o_offset", o_offset, k);
	endtask

	initial
	begin
		lfsr_state     = 32'hc8ca_9707;
		i_signal_ok    = 1'b0;
		i_word_valid   = 1'b0;
		i_word         = '0;
		mismatch_count = 0;
		other_count    = 0;
		skew           = 0;
		drv_w          = -1;
		corrupt_left   = 0;
		@(posedge i_rst_n);
		@(negedge i_clock);
		check_value("o_block_valid", o_block_valid, 0);
		check_value("o_block_lock", o_block_lock, 0);
		check_value("o_offset", o_offset, 0);
		for (int r = 0; r < N_ROWS; r++)
			run_row(skew_tab[r], corrupt_tab[r], loss_tab[r]);
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("error: timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count + 1);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+rtl
rtl/pcs_block_pkg.sv
rtl/block_lock_pkg.sv
rtl/aligned_block_if.sv
rtl/block_aligner.sv
rtl/block_sync_fsm.sv
rtl/pcs_block_sync.sv
bench/clock_gen.sv
bench/tb_pcs_block_sync.sv

/* rtl/aligned_block_if.sv */
`timescale 1ns/1ns
`include "pcs_params.svh"

interface aligned_block_if;

	logic                              blk_strobe; // one pulse per block
	logic                              sh_valid;
	logic                              is_ctrl;
	pcs_block_pkg::block_payload_u     payload;
	logic                              slip;       // one pulse, advance offset
	logic [$clog2(`PCS_BLOCK_LEN)-1:0] offset;

	modport aligner
	(
		output blk_strobe,
		output sh_valid,
		output is_ctrl,
		output payload,
		output offset,
		input  slip
	);

	// the lock machine only looks at header quality
	modport lock
	(
		input  blk_strobe,
		input  sh_valid,
		output slip
	);

endinterface

/* rtl/block_aligner.sv */
`timescale 1ns/1ns
`include "pcs_params.svh"

module block_aligner
(
	input  logic                         i_clock,
	input  logic                         i_rst_n,
	input  logic                         i_signal_ok,
	input  logic                         i_word_valid,
	input  logic [`PCS_BLOCK_LEN-1:0]    i_word,
	aligned_block_if.aligner             blk,
	output logic [7:0]                   o_block_type
);

	localparam int OFS_W = $clog2(`PCS_BLOCK_LEN);

	logic [`PCS_BLOCK_LEN-1:0]     prev_word;
	logic                          have_prev; // a previous word exists
	logic [2*`PCS_BLOCK_LEN-1:0]   stream;
	logic [`PCS_BLOCK_LEN-1:0]     window;
	logic [OFS_W-1:0]              offset;
	pcs_block_pkg::sync_header_t   header;
	pcs_block_pkg::block_payload_u payload_next;
	logic                          hdr_ok;
	logic                          hdr_ctrl;

	// older word sits in the low bits, bit 0 is the earliest on the line
	assign stream       = {i_word, prev_word};
	assign window       = stream[offset +: `PCS_BLOCK_LEN];
	assign header       = pcs_block_pkg::sync_header_t'(window[1:0]);
	assign payload_next = window[`PCS_BLOCK_LEN-1:2];

	assign hdr_ctrl = (header == pcs_block_pkg::SH_CTRL);
	assign hdr_ok   = hdr_ctrl || (header == pcs_block_pkg::SH_DATA);

	assign blk.offset = offset;

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			have_prev      <= 1'b0;
			offset         <= '0;
			blk.blk_strobe <= 1'b0;
			blk.sh_valid   <= 1'b0;
			blk.is_ctrl    <= 1'b0;
		end
		else if (!i_signal_ok)
		begin
			have_prev      <= 1'b0;
			offset         <= '0;
			blk.blk_strobe <= 1'b0;
			blk.sh_valid   <= 1'b0;
			blk.is_ctrl    <= 1'b0;
		end
		else
		begin
			if (i_word_valid)
			begin
				have_prev    <= 1'b1;
				blk.sh_valid <= hdr_ok;
				blk.is_ctrl  <= hdr_ctrl;
			end
			// a word taken during a slip was cut at the old offset, drop it
			blk.blk_strobe <= i_word_valid && have_prev && !blk.slip;
			if (blk.slip)
				offset <= (offset == OFS_W'(`PCS_BLOCK_LEN - 1)) ? '0 : offset + 1'b1;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_word_valid)
		begin
			prev_word    <= i_word;
			blk.payload  <= payload_next;
			o_block_type <= hdr_ctrl ? payload_next.ctrl.block_type : 8'h00;
		end
	end

	// a slip only ever answers the block just before it
	a_slip_after_block: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		blk.slip |-> $past(blk.blk_strobe)
	);

endmodule

/* rtl/block_lock_pkg.sv */
package block_lock_pkg;

	// lock machine states
	typedef enum logic [1:0]
	{
		LOCK_INIT = 2'd0, // counters cleared, waiting one cycle
		HUNT      = 2'd1, // unlocked, counting good headers
		LOCKED    = 2'd2  // locked, counting the window
	} lock_state_t;

endpackage

/* rtl/block_sync_fsm.sv */
`timescale 1ns/1ns
`include "pcs_params.svh"

module block_sync_fsm
(
	input  logic          i_clock,
	input  logic          i_rst_n,
	input  logic          i_signal_ok,
	aligned_block_if.lock blk,
	output logic          o_block_lock
);

	localparam int GOOD_W = $clog2(`PCS_GOOD_TO_LOCK);
	localparam int WIN_W  = $clog2(`PCS_SH_WINDOW);
	localparam int INV_W  = $clog2(`PCS_INVALID_LIMIT + 1);

	block_lock_pkg::lock_state_t state, state_next;
	logic [GOOD_W-1:0]           good_cnt, good_cnt_next;
	logic [WIN_W-1:0]            win_cnt, win_cnt_next;
	logic [INV_W-1:0]            inv_cnt, inv_cnt_next;
	logic                        slip_next;
	logic                        test_sh;

	// block seen in the slip cycle still came from the old offset
	assign test_sh = blk.blk_strobe && !blk.slip;

	assign o_block_lock = (state == block_lock_pkg::LOCKED);

	always_comb
	begin
		state_next    = state;
		good_cnt_next = good_cnt;
		win_cnt_next  = win_cnt;
		inv_cnt_next  = inv_cnt;
		slip_next     = 1'b0;

		case (state)
			block_lock_pkg::LOCK_INIT:
			begin
				good_cnt_next = '0;
				win_cnt_next  = '0;
				inv_cnt_next  = '0;
				state_next    = block_lock_pkg::HUNT;
			end
			block_lock_pkg::HUNT:
			begin
				if (test_sh)
				begin
					if (!blk.sh_valid)
					begin
						good_cnt_next = '0; // start over at next offset
						slip_next     = 1'b1;
					end
					else if (good_cnt == GOOD_W'(`PCS_GOOD_TO_LOCK - 1))
					begin
						good_cnt_next = '0;
						win_cnt_next  = '0;
						inv_cnt_next  = '0;
						state_next    = block_lock_pkg::LOCKED;
					end
					else
						good_cnt_next = good_cnt + 1'b1;
				end
			end
			block_lock_pkg::LOCKED:
			begin
				if (test_sh)
				begin
					if (!blk.sh_valid && inv_cnt == INV_W'(`PCS_INVALID_LIMIT - 1))
					begin
						win_cnt_next = '0;
						inv_cnt_next = '0;
						slip_next    = 1'b1;
						state_next   = block_lock_pkg::HUNT;
					end
					else if (win_cnt == WIN_W'(`PCS_SH_WINDOW - 1))
					begin
						win_cnt_next = '0; // window done, new one
						inv_cnt_next = '0;
					end
					else
					begin
						win_cnt_next = win_cnt + 1'b1;
						if (!blk.sh_valid)
							inv_cnt_next = inv_cnt + 1'b1;
					end
				end
			end
			default:
				state_next = block_lock_pkg::LOCK_INIT;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state    <= block_lock_pkg::LOCK_INIT;
			good_cnt <= '0;
			win_cnt  <= '0;
			inv_cnt  <= '0;
			blk.slip <= 1'b0;
		end
		else if (!i_signal_ok)
		begin
			state    <= block_lock_pkg::LOCK_INIT; // restart acquisition
			good_cnt <= '0;
			win_cnt  <= '0;
			inv_cnt  <= '0;
			blk.slip <= 1'b0;
		end
		else
		begin
			state    <= state_next;
			good_cnt <= good_cnt_next;
			win_cnt  <= win_cnt_next;
			inv_cnt  <= inv_cnt_next;
			blk.slip <= slip_next;
		end
	end

	a_slip_pulse: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		blk.slip |=> !blk.slip
	);

	a_inv_limit: assert property (
		@(posedge i_clock) disable iff (!i_rst_n)
		inv_cnt < INV_W'(`PCS_INVALID_LIMIT)
	);

endmodule

/* rtl/pcs_block_pkg.sv */
`include "pcs_params.svh"

package pcs_block_pkg;

	// header bits as sent, bit 0 goes out first
	// so "01" on the line is 2'b10 here and "10" is 2'b01
	typedef enum logic [1:0]
	{
		SH_DATA = 2'b10,
		SH_CTRL = 2'b01
	} sync_header_t;

	// control block layout, type byte is the first octet on the line
	typedef struct packed
	{
		logic [`PCS_PAYLOAD_LEN-9:0] fields; // rest of the control word
		logic [7:0]                  block_type;
	} ctrl_view_t;

	// one payload word, read as octets or as a control word
	typedef union packed
	{
		logic [`PCS_PAYLOAD_LEN/8-1:0][7:0] octet; // octet[0] sent first
		ctrl_view_t                         ctrl;
	} block_payload_u;

endpackage

/* rtl/pcs_block_sync.sv */
`timescale 1ns/1ns
`include "pcs_params.svh"

module pcs_block_sync
(
	input  logic                              i_clock,
	input  logic                              i_rst_n,
	input  logic                              i_signal_ok,
	input  logic                              i_word_valid,
	input  logic [`PCS_BLOCK_LEN-1:0]         i_word,
	output logic                              o_block_valid,
	output logic                              o_block_lock,
	output logic                              o_block_is_ctrl,
	output logic [`PCS_PAYLOAD_LEN-1:0]       o_block_payload,
	output logic [7:0]                        o_block_type,
	output logic [$clog2(`PCS_BLOCK_LEN)-1:0] o_offset
);

	aligned_block_if blk_if ();

	block_aligner u_aligner
	(
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_signal_ok  (i_signal_ok),
		.i_word_valid (i_word_valid),
		.i_word       (i_word),
		.blk          (blk_if),
		.o_block_type (o_block_type)
	);

	block_sync_fsm u_lock_fsm
	(
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_signal_ok  (i_signal_ok),
		.blk          (blk_if),
		.o_block_lock (o_block_lock)
	);

	assign o_block_valid   = blk_if.blk_strobe;
	assign o_block_is_ctrl = blk_if.is_ctrl;
	assign o_block_payload = blk_if.payload.octet; // octet 0 in the low byte
	assign o_offset        = blk_if.offset;

endmodule

/* rtl/pcs_params.svh */
`ifndef PCS_PARAMS_SVH
`define PCS_PARAMS_SVH

// coded block, also the number of slip offsets
`define PCS_BLOCK_LEN 66

// block minus its 2-bit sync header
`define PCS_PAYLOAD_LEN 64

// consecutive good headers before lock
`define PCS_GOOD_TO_LOCK 64

// headers per window while locked
`define PCS_SH_WINDOW 1024

// bad headers in one window that drop lock
`define PCS_INVALID_LIMIT 65

`endif
